/* common/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    localparam int addr_width    = 10;
    localparam int data_width    = 32;
    localparam int mask_width    = data_width / 8;      // One enable per byte.
    localparam int port_id_width = 3;
    localparam int mem_id_width  = port_id_width + 1;   // Port index on top.

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } mem_op_t;

    // A request as one port issues it.
    typedef struct packed {
        mem_op_t                  op;
        logic [mask_width-1:0]    mask;
        logic [addr_width-1:0]    addr;
        logic [data_width-1:0]    data;
        logic [port_id_width-1:0] id;
        logic                     last;
    } mem_req_t;

    // The same request after the merge, with the port index prepended to the id.
    typedef struct packed {
        mem_op_t                  op;
        logic [mask_width-1:0]    mask;
        logic [addr_width-1:0]    addr;
        logic [data_width-1:0]    data;
        logic [mem_id_width-1:0]  id;
        logic                     last;
    } mem_tagged_req_t;

    typedef struct packed {
        mem_op_t                  op;
        logic [data_width-1:0]    data;   // Zero for writes.
        logic [mem_id_width-1:0]  id;
    } mem_resp_t;

endpackage

`default_nettype wire

/* common/merge_pkg.sv */
`default_nettype none

package merge_pkg;

    // How the arbiter picks when both ports are valid.
    typedef enum logic {
        select_round_robin = 1'b0,
        select_priority    = 1'b1     // Port 0 always wins.
    } select_mode_t;

    typedef enum logic {
        arb_idle   = 1'b0,
        arb_locked = 1'b1             // Inside a burst, waiting for last.
    } arb_state_t;

endpackage

`default_nettype wire

/* mem_merge/mem_merge.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_merge #(
    parameter merge_pkg::select_mode_t SELECT_MODE = merge_pkg::select_round_robin,
    parameter bit                      USE_LAST    = 1'b1
) (
    input  wire                         clk,
    input  wire                         rst_n,

    input  wire                         req_valid0,
    input  wire mem_pkg::mem_req_t      req0,
    output logic                        req_ready0,

    input  wire                         req_valid1,
    input  wire mem_pkg::mem_req_t      req1,
    output logic                        req_ready1,

    output logic                        out_valid,
    output mem_pkg::mem_tagged_req_t    out_req,
    input  wire                         out_ready
);

    import mem_pkg::*;

    logic     buf0_valid;
    mem_req_t buf0_req;
    logic     buf0_ready;
    logic     buf1_valid;
    mem_req_t buf1_req;
    logic     buf1_ready;

    mem_port_buffer u_buf0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_valid0),
        .in_req    (req0),
        .in_ready  (req_ready0),
        .out_valid (buf0_valid),
        .out_req   (buf0_req),
        .out_ready (buf0_ready)
    );

    mem_port_buffer u_buf1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_valid1),
        .in_req    (req1),
        .in_ready  (req_ready1),
        .out_valid (buf1_valid),
        .out_req   (buf1_req),
        .out_ready (buf1_ready)
    );

    // Both buffers cut the ready path, so the choice below sees only registered valids.
    mem_merge_arbiter #(
        .SELECT_MODE (SELECT_MODE),
        .USE_LAST    (USE_LAST)
    ) u_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .in0_valid (buf0_valid),
        .in0_req   (buf0_req),
        .in0_ready (buf0_ready),
        .in1_valid (buf1_valid),
        .in1_req   (buf1_req),
        .in1_ready (buf1_ready),
        .out_valid (out_valid),
        .out_req   (out_req),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

/* mem_merge/mem_merge_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_merge_arbiter #(
    parameter merge_pkg::select_mode_t SELECT_MODE = merge_pkg::select_round_robin,
    parameter bit                      USE_LAST    = 1'b1
) (
    input  wire                         clk,
    input  wire                         rst_n,

    input  wire                         in0_valid,
    input  wire mem_pkg::mem_req_t      in0_req,
    output logic                        in0_ready,

    input  wire                         in1_valid,
    input  wire mem_pkg::mem_req_t      in1_req,
    output logic                        in1_ready,

    output logic                        out_valid,
    output mem_pkg::mem_tagged_req_t    out_req,
    input  wire                         out_ready
);

    import mem_pkg::*;
    import merge_pkg::*;

    arb_state_t state;
    logic       rr_ptr;       // Port with priority in round-robin mode.
    logic       lock_port;
    logic       prio_port;
    logic       grant0;
    logic       grant1;
    logic       win_port;
    mem_req_t   win_req;
    logic       load_en;
    logic       take;

    assign prio_port = (SELECT_MODE == select_priority) ? 1'b0 : rr_ptr;

    always_comb begin
        grant0 = 1'b0;
        grant1 = 1'b0;
        if (state == arb_locked) begin
            grant0 = in0_valid && !lock_port;
            grant1 = in1_valid && lock_port;
        end else if (in0_valid && in1_valid) begin
            grant0 = !prio_port;
            grant1 = prio_port;
        end else begin
            grant0 = in0_valid;
            grant1 = in1_valid;
        end
    end

    assign win_port  = grant1;
    assign win_req   = grant1 ? in1_req : in0_req;
    assign load_en   = !out_valid || out_ready;   // Output register free this cycle.
    assign take      = load_en && (grant0 || grant1);
    assign in0_ready = load_en && grant0;
    assign in1_ready = load_en && grant1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            state     <= arb_idle;
            rr_ptr    <= 1'b0;
            lock_port <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
            rr_ptr    <= !win_port;   // The other port goes first next time.
            lock_port <= win_port;
            if (USE_LAST && !win_req.last) begin
                state <= arb_locked;
            end else begin
                state <= arb_idle;
            end
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_req.op   <= win_req.op;
            out_req.mask <= win_req.mask;
            out_req.addr <= win_req.addr;
            out_req.data <= win_req.data;
            out_req.id   <= {win_port, win_req.id};
            out_req.last <= win_req.last;
        end
    end

endmodule

`default_nettype wire

/* mem_merge/mem_port_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_port_buffer (
    input  wire                    clk,
    input  wire                    rst_n,

    input  wire                    in_valid,
    input  wire mem_pkg::mem_req_t in_req,
    output logic                   in_ready,

    output logic                   out_valid,
    output mem_pkg::mem_req_t      out_req,
    input  wire                    out_ready
);

    import mem_pkg::*;

    logic     main_valid;
    mem_req_t main_req;
    logic     spill_valid;
    mem_req_t spill_req;
    logic     in_take;
    logic     main_free;

    assign in_take   = in_valid && in_ready;
    assign main_free = !main_valid || out_ready;    // Main register empties or drains now.

    // Ready comes from a register only, so the arbiter's ready never reaches the port.
    assign in_ready  = !spill_valid;
    assign out_valid = main_valid;
    assign out_req   = main_req;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            main_valid  <= 1'b0;
            spill_valid <= 1'b0;
        end else if (main_free) begin
            if (spill_valid) begin
                main_valid  <= 1'b1;
                spill_valid <= 1'b0;
            end else begin
                main_valid <= in_take;
            end
        end else if (in_take) begin
            spill_valid <= 1'b1;  // Main is stalled, so park the new request.
        end
    end

    always_ff @(posedge clk) begin
        if (main_free) begin
            main_req <= spill_valid ? spill_req : in_req;
        end
        if (!main_free && in_take) begin
            spill_req <= in_req;
        end
    end

endmodule

`default_nettype wire

/* project.f */
common/mem_pkg.sv
common/merge_pkg.sv
mem_merge/mem_port_buffer.sv
mem_merge/mem_merge_arbiter.sv
mem_merge/mem_merge.sv
source/mem_ram.sv
source/mem_resp_route.sv
source/mem_subsystem.sv
sim/tb_mem_subsystem.sv

/* sim/tb_mem_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_subsystem;

    import mem_pkg::*;

    localparam int depth_log2  = 8;
    localparam int n_fill      = 256;
    localparam int n_wr        = 16;
    localparam int n_rand      = 150;
    localparam int n_burst     = 32;
    localparam int n_rr        = 40;
    localparam int total_reqs  = n_fill + 2 * n_wr + 4 * n_rand + 4 * n_burst + 2 * n_rr;
    localparam int cycle_limit = 4 * total_reqs + 200;

    logic      clk;
    logic      rst_n;
    logic      req_valid0;
    mem_req_t  req0;
    logic      req_ready0;
    logic      resp_valid0;
    mem_resp_t resp0;
    logic      resp_ready0;
    logic      req_valid1;
    mem_req_t  req1;
    logic      req_ready1;
    logic      resp_valid1;
    mem_resp_t resp1;
    logic      resp_ready1;

    logic [data_width-1:0] model [2**depth_log2];   // Expected RAM contents.
    logic [addr_width-1:0] wr_addr [n_wr];
    logic [31:0]           seeds [3];               // Port 0, port 1, back-pressure.
    mem_req_t              pend0 [$];
    mem_req_t              pend1 [$];
    int                    errors;
    int                    sent_count [2];
    int                    resp_count [2];
    int                    cycles;
    logic                  bp_on;
    logic                  rr_on;
    logic                  rr_have_prev;
    logic                  rr_prev;
    logic                  burst_open;
    logic                  burst_port;

    mem_subsystem u_mem_subsystem (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid0  (req_valid0),
        .req0        (req0),
        .req_ready0  (req_ready0),
        .resp_valid0 (resp_valid0),
        .resp0       (resp0),
        .resp_ready0 (resp_ready0),
        .req_valid1  (req_valid1),
        .req1        (req1),
        .req_ready1  (req_ready1),
        .resp_valid1 (resp_valid1),
        .resp1       (resp1),
        .resp_ready1 (resp_ready1)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] rand_next(input int ch);
        seeds[ch] = seeds[ch] * 32'd1664525 + 32'd1013904223;
        return seeds[ch];
    endfunction

    // Applies one request to the model in merged order and returns the data a response carries.
    function automatic logic [data_width-1:0] ref_access(input mem_req_t r);
        logic [depth_log2-1:0] idx;
        idx = r.addr[depth_log2-1:0];
        if (r.op == op_read) begin
            return model[idx];
        end
        for (int b = 0; b < mask_width; b++) begin
            if (r.mask[b]) begin
                model[idx][8*b +: 8] = r.data[8*b +: 8];
            end
        end
        return '0;
    endfunction

    function automatic mem_req_t make_req(input int ch, input int idx, input bit last);
        mem_req_t    r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        a = rand_next(ch);
        b = rand_next(ch);
        c = rand_next(ch);
        r.op   = a[31] ? op_write : op_read;   // The low LCG bits repeat quickly and are not used.
        r.mask = a[30:27];
        r.addr = b[31:22];
        r.data = {c[31:16], b[21:6]};
        r.id   = idx[port_id_width-1:0];
        r.last = last;
        return r;
    endfunction

    // Called on a falling edge; returns on the falling edge after the transfer.
    task automatic send_req(input int p, input mem_req_t r);
        if (p == 0) begin
            req_valid0 = 1'b1;
            req0       = r;
            while (req_ready0 !== 1'b1) @(negedge clk);
            pend0.push_back(r);
        end else begin
            req_valid1 = 1'b1;
            req1       = r;
            while (req_ready1 !== 1'b1) @(negedge clk);
            pend1.push_back(r);
        end
        sent_count[p]++;
        @(negedge clk);
    endtask

    task automatic run_port(input int p, input int count, input int burst_len);
        for (int i = 0; i < count; i++) begin
            send_req(p, make_req(p, i, (i % burst_len) == burst_len - 1));
        end
        if (p == 0) req_valid0 = 1'b0;
        else req_valid1 = 1'b0;
    endtask

    task automatic wait_drain();
        while (pend0.size() != 0 || pend1.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    task automatic check_idle();
        if (resp_valid0 !== 1'b0) begin
            errors++;
            $display("ERR resp_valid0 expected %h got %h", 1'b0, resp_valid0);
        end
        if (resp_valid1 !== 1'b0) begin
            errors++;
            $display("ERR resp_valid1 expected %h got %h", 1'b0, resp_valid1);
        end
        if (req_ready0 !== 1'b1) begin
            errors++;
            $display("ERR req_ready0 expected %h got %h", 1'b1, req_ready0);
        end
        if (req_ready1 !== 1'b1) begin
            errors++;
            $display("ERR req_ready1 expected %h got %h", 1'b1, req_ready1);
        end
    endtask

    task automatic check_resp(input int p, input mem_resp_t r);
        mem_req_t                e;
        logic [data_width-1:0]   exp_data;
        logic [mem_id_width-1:0] exp_id;
        logic                    other_pending;
        resp_count[p]++;
        if ((p == 0 && pend0.size() == 0) || (p == 1 && pend1.size() == 0)) begin
            errors++;
            $display("Port %0d returned a response with no request outstanding", p);
            return;
        end
        if (p == 0) e = pend0.pop_front();
        else e = pend1.pop_front();
        other_pending = (p == 0) ? (pend1.size() != 0) : (pend0.size() != 0);
        exp_data = ref_access(e);
        exp_id   = {p[0], e.id};
        if (r.id !== exp_id) begin
            errors++;
            $display("ERR resp%0d.id expected %h got %h", p, exp_id, r.id);
        end
        if (r.op !== e.op) begin
            errors++;
            $display("ERR resp%0d.op expected %h got %h", p, e.op, r.op);
        end
        if (r.data !== exp_data) begin
            errors++;
            $display("ERR resp%0d.data expected %h got %h", p, exp_data, r.data);
        end
        if (burst_open && burst_port != p[0]) begin
            errors++;
            $display("Port %0d response came inside a burst of port %0d", p, burst_port);
        end
        burst_open = !e.last;
        burst_port = p[0];
        if (rr_on && rr_have_prev && rr_prev == p[0] && other_pending) begin
            errors++;
            $display("Port %0d was granted twice in a row while the other port waited", p);
        end
        rr_prev      = p[0];
        rr_have_prev = 1'b1;
    endtask

    // The response side is sampled on the falling edge, right after its ready is chosen.
    always @(negedge clk) begin
        logic [31:0] v;
        v = rand_next(2);
        resp_ready0 = !bp_on || (v[31:30] != 2'b00);
        resp_ready1 = !bp_on || (v[29:28] != 2'b00);
        if (rst_n === 1'b1 && resp_valid0 === 1'b1 && resp_ready0) check_resp(0, resp0);
        if (rst_n === 1'b1 && resp_valid1 === 1'b1 && resp_ready1) check_resp(1, resp1);
    end

    task automatic print_summary(input bit timed_out);
        $display("Errors: %0d  sent: %0d/%0d  responses: %0d/%0d", errors,
                 sent_count[0], sent_count[1], resp_count[0], resp_count[1]);
        if (errors == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped after %0d cycles without reaching the end of the tests", cycles);
        print_summary(1'b1);
        $finish;
    end

    initial begin
        mem_req_t r;
        seeds[0]      = 32'd41440;
        seeds[1]      = 32'd41440 ^ 32'h5bd1e995;
        seeds[2]      = 32'd41440 ^ 32'h27d4eb2f;
        errors        = 0;
        sent_count    = '{0, 0};
        resp_count    = '{0, 0};
        bp_on         = 1'b0;
        rr_on         = 1'b0;
        rr_have_prev  = 1'b0;
        rr_prev       = 1'b0;
        burst_open    = 1'b0;
        burst_port    = 1'b0;
        req_valid0    = 1'b0;
        req0          = '0;
        resp_ready0   = 1'b1;
        req_valid1    = 1'b0;
        req1          = '0;
        resp_ready1   = 1'b1;
        rst_n         = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (8) begin
            @(negedge clk);
            check_idle();
        end
        // Every word gets a known value first, since the RAM is not reset.
        for (int a = 0; a < n_fill; a++) begin
            r      = make_req(1, a, 1'b1);
            r.op   = op_write;
            r.mask = '1;
            r.addr = a[addr_width-1:0];
            send_req(1, r);
        end
        req_valid1 = 1'b0;
        wait_drain();
        for (int i = 0; i < n_wr; i++) begin
            r          = make_req(0, i, 1'b1);
            r.op       = op_write;
            wr_addr[i] = r.addr;
            send_req(0, r);
        end
        for (int i = 0; i < n_wr; i++) begin
            r      = make_req(0, i, 1'b1);
            r.op   = op_read;
            r.addr = wr_addr[i] + 10'd256;   // Same word once the address wraps.
            send_req(0, r);
        end
        req_valid0 = 1'b0;
        wait_drain();
        fork
            run_port(0, n_rand, 1);
            run_port(1, n_rand, 1);
        join
        wait_drain();
        bp_on = 1'b1;
        fork
            run_port(0, n_rand, 1);
            run_port(1, n_rand, 1);
        join
        wait_drain();
        bp_on = 1'b0;
        fork
            run_port(0, n_burst, 4);
            run_port(1, n_burst, 1);
        join
        wait_drain();
        fork
            run_port(0, n_burst, 1);
            run_port(1, n_burst, 4);
        join
        wait_drain();
        rr_have_prev = 1'b0;
        rr_on        = 1'b1;
        fork
            run_port(0, n_rr, 1);
            run_port(1, n_rr, 1);
        join
        wait_drain();
        rr_on = 1'b0;
        for (int k = 0; k < 2; k++) begin
            if (resp_count[k] != sent_count[k]) begin
                errors++;
                $display("Port %0d sent %0d requests but got %0d responses", k,
                         sent_count[k], resp_count[k]);
            end
        end
        print_summary(1'b0);
        $finish;
    end

endmodule

`default_nettype wire

/* source/mem_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_ram #(
    parameter int DEPTH_LOG2 = 8
) (
    input  wire                         clk,
    input  wire                         rst_n,

    input  wire                         req_valid,
    input  wire mem_pkg::mem_tagged_req_t req,
    output logic                        req_ready,

    output logic                        resp_valid,
    output mem_pkg::mem_resp_t          resp,
    input  wire                         resp_ready
);

    import mem_pkg::*;

    localparam int depth = 2 ** DEPTH_LOG2;

    logic [data_width-1:0] mem [depth];
    logic [DEPTH_LOG2-1:0] index;
    logic                  take;

    assign index     = req.addr[DEPTH_LOG2-1:0];  // Upper address bits wrap.
    assign req_ready = !resp_valid || resp_ready;
    assign take      = req_valid && req_ready;

    // Only the bytes with a set mask bit change.
    always_ff @(posedge clk) begin
        if (take && req.op == op_write) begin
            for (int b = 0; b < mask_width; b++) begin
                if (req.mask[b]) begin
                    mem[index][8*b +: 8] <= req.data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else if (take) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            resp.op   <= req.op;
            resp.id   <= req.id;
            resp.data <= (req.op == op_read) ? mem[index] : '0;
        end
    end

endmodule

`default_nettype wire

/* source/mem_resp_route.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_resp_route (
    input  wire                     in_valid,
    input  wire mem_pkg::mem_resp_t in_resp,
    output logic                    in_ready,

    output logic                    resp_valid0,
    output mem_pkg::mem_resp_t      resp0,
    input  wire                     resp_ready0,

    output logic                    resp_valid1,
    output mem_pkg::mem_resp_t      resp1,
    input  wire                     resp_ready1
);

    import mem_pkg::*;

    logic port_sel;

    // The top id bit is the port index added by the arbiter.
    assign port_sel = in_resp.id[mem_id_width-1];

    assign resp_valid0 = in_valid && !port_sel;
    assign resp_valid1 = in_valid && port_sel;
    assign resp0       = in_resp;
    assign resp1       = in_resp;

    assign in_ready = port_sel ? resp_ready1 : resp_ready0;  // A stall on one port holds both.

endmodule

`default_nettype wire

/* source/mem_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_subsystem #(
    parameter merge_pkg::select_mode_t SELECT_MODE = merge_pkg::select_round_robin,
    parameter bit                      USE_LAST    = 1'b1,
    parameter int                      DEPTH_LOG2  = 8
) (
    input  wire                     clk,
    input  wire                     rst_n,

    input  wire                     req_valid0,
    input  wire mem_pkg::mem_req_t  req0,
    output logic                    req_ready0,
    output logic                    resp_valid0,
    output mem_pkg::mem_resp_t      resp0,
    input  wire                     resp_ready0,

    input  wire                     req_valid1,
    input  wire mem_pkg::mem_req_t  req1,
    output logic                    req_ready1,
    output logic                    resp_valid1,
    output mem_pkg::mem_resp_t      resp1,
    input  wire                     resp_ready1
);

    import mem_pkg::*;

    logic            merged_valid;
    mem_tagged_req_t merged_req;
    logic            merged_ready;
    logic            ram_resp_valid;
    mem_resp_t       ram_resp;
    logic            ram_resp_ready;

    mem_merge #(
        .SELECT_MODE (SELECT_MODE),
        .USE_LAST    (USE_LAST)
    ) u_mem_merge (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid0 (req_valid0),
        .req0       (req0),
        .req_ready0 (req_ready0),
        .req_valid1 (req_valid1),
        .req1       (req1),
        .req_ready1 (req_ready1),
        .out_valid  (merged_valid),
        .out_req    (merged_req),
        .out_ready  (merged_ready)
    );

    mem_ram #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) u_mem_ram (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (merged_valid),
        .req        (merged_req),
        .req_ready  (merged_ready),
        .resp_valid (ram_resp_valid),
        .resp       (ram_resp),
        .resp_ready (ram_resp_ready)
    );

    mem_resp_route u_mem_resp_route (
        .in_valid    (ram_resp_valid),
        .in_resp     (ram_resp),
        .in_ready    (ram_resp_ready),
        .resp_valid0 (resp_valid0),
        .resp0       (resp0),
        .resp_ready0 (resp_ready0),
        .resp_valid1 (resp_valid1),
        .resp1       (resp1),
        .resp_ready1 (resp_ready1)
    );

endmodule

`default_nettype wire
